// File: rtl/cpu_pkg.sv
// CPU package with opcode, bus device, target and condition encodings and field widths
`default_nettype none

package cpu_pkg;

    localparam int instr_w  = 32;  // Instruction word from external ROM
    localparam int alu_op_w = 5;
    localparam int tdev_w   = 4;
    localparam int adev_w   = 3;
    localparam int bdev_w   = 3;
    localparam int cond_w   = 4;

    // ALU operation, compare only sets flags
    typedef enum logic [alu_op_w-1:0] {
        op_pass_a = 5'd0,
        op_pass_b, op_add, op_addc, op_sub, op_subb,
        op_and, op_or, op_xor, op_not_a, op_shl, op_shr, op_cmp
    } alu_op_e;

    // A bus sources, regs first so low bits are the regfile address
    typedef enum logic [adev_w-1:0] {
        adev_rega = 3'd0,
        adev_regb, adev_regc, adev_regd,
        adev_marlo, adev_marhi, adev_uart, adev_zero
    } adev_e;

    // B bus sources
    typedef enum logic [bdev_w-1:0] {
        bdev_rega = 3'd0,
        bdev_regb, bdev_regc, bdev_regd,
        bdev_marlo, bdev_marhi, bdev_ram, bdev_immed
    } bdev_e;

    // Targets; regs at 4..7 so tdev[1:0] is the write address
    typedef enum logic [tdev_w-1:0] {
        tdev_none    = 4'd0,
        tdev_marlo   = 4'd1,
        tdev_marhi   = 4'd2,
        tdev_ram     = 4'd3,
        tdev_rega    = 4'd4,
        tdev_regb    = 4'd5,
        tdev_regc    = 4'd6,
        tdev_regd    = 4'd7,
        tdev_uart    = 4'd8,
        tdev_pclo    = 4'd9,   // Local jump within page
        tdev_pchitmp = 4'd10,  // Stage high byte
        tdev_pc      = 4'd11   // Conditional long jump
    } tdev_e;

    // Long jump condition
    typedef enum logic [cond_w-1:0] {
        cond_always = 4'd0,
        cond_c, cond_z, cond_o, cond_n,
        cond_eq, cond_ne, cond_gt, cond_lt,
        cond_di, cond_do
    } cond_e;

    // Bit positions in the 8-bit flag word
    typedef enum logic [2:0] {
        flag_ne = 3'd0,
        flag_eq, flag_lt, flag_gt, flag_n, flag_o, flag_z, flag_c
    } flag_idx_e;

endpackage

`default_nettype wire

// File: rtl/instr_decoder.sv
// Instruction decoder splitting the word into ALU op, bus selects, target and operands
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  logic [cpu_pkg::instr_w-1:0] instr,
    output cpu_pkg::alu_op_e            alu_op,
    output cpu_pkg::adev_e              adev,
    output cpu_pkg::bdev_e              bdev,
    output cpu_pkg::tdev_e              tdev,
    output cpu_pkg::cond_e              cond,
    output logic                        addr_direct,
    output logic [7:0]                  immed8
);

    // Word layout, top down
    //   [31:27] alu op   [26:23] target   [22:20] A src   [19:17] B src
    //   [16:13] cond     [12] direct      [11:8] spare    [7:0] immed / address
    assign alu_op = cpu_pkg::alu_op_e'(instr[31:27]);
    assign adev   = cpu_pkg::adev_e'(instr[22:20]);   // All 8 codes legal
    assign bdev   = cpu_pkg::bdev_e'(instr[19:17]);
    assign cond   = cpu_pkg::cond_e'(instr[16:13]);   // Spare codes never jump

    // Unused target codes fold to none so nothing gets written
    assign tdev = (instr[26:23] > cpu_pkg::tdev_pc) ? cpu_pkg::tdev_none
                                                    : cpu_pkg::tdev_e'(instr[26:23]);

    assign addr_direct = instr[12];    // Else MARLO addressing
    assign immed8      = instr[7:0];   // Shared by immediate and direct address

endmodule

`default_nettype wire

// File: rtl/program_counter.sv
// Program counter with increment, page-local jump and conditional long jump through a high temp
`timescale 1ns/1ps
`default_nettype none

module program_counter (
    input  logic           clk,
    input  logic           reset,
    input  cpu_pkg::tdev_e tdev,
    input  cpu_pkg::cond_e cond,
    input  logic [7:0]     flags,           // Registered ALU flags
    input  logic           data_in_avail,
    input  logic           data_out_ready,
    input  logic [7:0]     result,          // ALU result bus
    output logic [15:0]    pc
);

    logic [7:0] pchi_tmp;   // High byte staged for next long jump
    logic       cond_true;

    // Only place the jump condition is evaluated
    always_comb begin
        case (cond)
            cpu_pkg::cond_always: cond_true = 1'b1;
            cpu_pkg::cond_c:      cond_true = flags[cpu_pkg::flag_c];
            cpu_pkg::cond_z:      cond_true = flags[cpu_pkg::flag_z];
            cpu_pkg::cond_o:      cond_true = flags[cpu_pkg::flag_o];
            cpu_pkg::cond_n:      cond_true = flags[cpu_pkg::flag_n];
            cpu_pkg::cond_eq:     cond_true = flags[cpu_pkg::flag_eq];
            cpu_pkg::cond_ne:     cond_true = flags[cpu_pkg::flag_ne];
            cpu_pkg::cond_gt:     cond_true = flags[cpu_pkg::flag_gt];
            cpu_pkg::cond_lt:     cond_true = flags[cpu_pkg::flag_lt];
            cpu_pkg::cond_di:     cond_true = data_in_avail;    // UART byte waiting
            cpu_pkg::cond_do:     cond_true = data_out_ready;   // Transmit credit held
            default:              cond_true = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= '0;
            pchi_tmp <= '0;
        end else begin
            case (tdev)
                cpu_pkg::tdev_pchitmp: begin
                    pchi_tmp <= result;
                    pc       <= pc + 16'd1;
                end
                cpu_pkg::tdev_pclo: pc <= {pc[15:8], result};   // Page stays the same
                cpu_pkg::tdev_pc:   pc <= cond_true ? {pchi_tmp, result} : pc + 16'd1;
                default:            pc <= pc + 16'd1;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/register_file.sv
// Register file of four 8-bit registers, two combinational read ports and one write port
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic       clk,
    input  logic       reset,
    input  logic       wr_en,
    input  logic [1:0] wr_addr,
    input  logic [7:0] wr_data,
    input  logic [1:0] rd_a_addr,   // A bus port
    input  logic [1:0] rd_b_addr,   // B bus port
    output logic [7:0] rd_a_data,
    output logic [7:0] rd_b_data
);

    logic [7:0] regs [4];   // A, B, C, D

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;   // Same-cycle read still sees old value
        end
    end

    assign rd_a_data = regs[rd_a_addr];
    assign rd_b_data = regs[rd_b_addr];

endmodule

`default_nettype wire

// File: rtl/alu.sv
// Eight-bit ALU producing the result bus and the eight condition flags
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [7:0]       a,
    input  logic [7:0]       b,
    input  cpu_pkg::alu_op_e alu_op,
    input  logic             carry_in,    // Registered carry, no-borrow on subtract
    output logic [7:0]       result,
    output logic [7:0]       flags_out
);

    logic       is_sub;
    logic       cin;
    logic [7:0] b_eff;       // B inverted for subtract family
    logic [8:0] sum;
    logic       carry;
    logic       overflow;

    assign is_sub = alu_op inside {cpu_pkg::op_sub, cpu_pkg::op_subb, cpu_pkg::op_cmp};
    assign b_eff  = is_sub ? ~b : b;
    // Chained ops take the stored carry, plain subtract adds the two's complement one
    assign cin = (alu_op inside {cpu_pkg::op_addc, cpu_pkg::op_subb}) ? carry_in : is_sub;
    assign sum = {1'b0, a} + {1'b0, b_eff} + {8'd0, cin};

    always_comb begin
        carry    = 1'b0;
        overflow = 1'b0;
        case (alu_op)
            cpu_pkg::op_pass_a: result = a;
            cpu_pkg::op_pass_b: result = b;
            cpu_pkg::op_add, cpu_pkg::op_addc, cpu_pkg::op_sub,
            cpu_pkg::op_subb, cpu_pkg::op_cmp: begin
                result   = sum[7:0];
                carry    = sum[8];
                // Signed overflow, operands agree in sign but result differs
                overflow = (a[7] == b_eff[7]) && (sum[7] != a[7]);
            end
            cpu_pkg::op_and:    result = a & b;
            cpu_pkg::op_or:     result = a | b;
            cpu_pkg::op_xor:    result = a ^ b;
            cpu_pkg::op_not_a:  result = ~a;
            cpu_pkg::op_shl: begin
                result = {a[6:0], 1'b0};
                carry  = a[7];          // Bit shifted out
            end
            cpu_pkg::op_shr: begin
                result = {1'b0, a[7:1]};
                carry  = a[0];
            end
            default:            result = a;
        endcase
    end

    // Magnitude flags compare raw operands unsigned for every op
    always_comb begin
        flags_out[cpu_pkg::flag_c]  = carry;
        flags_out[cpu_pkg::flag_z]  = (result == 8'd0);
        flags_out[cpu_pkg::flag_o]  = overflow;
        flags_out[cpu_pkg::flag_n]  = result[7];
        flags_out[cpu_pkg::flag_gt] = (a > b);
        flags_out[cpu_pkg::flag_lt] = (a < b);
        flags_out[cpu_pkg::flag_eq] = (a == b);
        flags_out[cpu_pkg::flag_ne] = (a != b);
    end

endmodule

`default_nettype wire

// File: rtl/data_memory.sv
// Data memory with the MAR pair, direct or MAR addressing, and the data RAM
`timescale 1ns/1ps
`default_nettype none

module data_memory #(
    parameter int RAM_DEPTH = 256     // Power of two, at most 256
) (
    input  logic           clk,
    input  logic           reset,
    input  cpu_pkg::tdev_e tdev,
    input  logic           addr_direct,
    input  logic [7:0]     direct_addr,   // Address field of the instruction
    input  logic [7:0]     wr_data,       // ALU result
    output logic [7:0]     marlo,
    output logic [7:0]     marhi,
    output logic [7:0]     ram_rdata
);

    localparam int addr_w = $clog2(RAM_DEPTH);

    logic [7:0]        ram [RAM_DEPTH];
    logic [7:0]        addr_full;
    logic [addr_w-1:0] ram_addr;

    // MARHI is a plain arithmetic register here, 256 bytes need only MARLO
    assign addr_full = addr_direct ? direct_addr : marlo;
    assign ram_addr  = addr_full[addr_w-1:0];   // Wraps on a smaller RAM
    assign ram_rdata = ram[ram_addr];

    always_ff @(posedge clk) begin
        if (reset) begin
            marlo <= '0;
            marhi <= '0;
        end else begin
            if (tdev == cpu_pkg::tdev_marlo) marlo <= wr_data;
            if (tdev == cpu_pkg::tdev_marhi) marhi <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (tdev == cpu_pkg::tdev_ram) begin
            ram[ram_addr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// File: rtl/uart_port.sv
// UART byte port with transmit credit counter, two-entry receive FIFO and receive credit return
`timescale 1ns/1ps
`default_nettype none

module uart_port #(
    parameter int TX_CREDITS = 2
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       tx_wr,           // Target is UART transmit
    input  logic [7:0] wr_data,
    input  logic       rx_rd,           // A bus selects UART receive
    input  logic       tx_credit,       // One credit back from the receiver
    input  logic       rx_valid,
    input  logic [7:0] rx_data,
    output logic       tx_valid,
    output logic [7:0] tx_data,
    output logic       rx_credit,       // One credit back to the sender
    output logic [7:0] rx_byte,
    output logic       data_in_avail,
    output logic       data_out_ready
);

    localparam int cnt_w = $clog2(TX_CREDITS + 1);

    logic [cnt_w-1:0] tx_cnt;      // Transmit credits held
    logic             tx_fire;
    logic [7:0]       rx_mem [2];
    logic             rx_wr_ptr;
    logic             rx_rd_ptr;
    logic [1:0]       rx_cnt;      // 0..2 entries
    logic             rx_push;
    logic             rx_pop;

    assign data_out_ready = (tx_cnt != '0);
    assign tx_fire        = tx_wr && data_out_ready;   // No credit, byte dropped

    always_ff @(posedge clk) begin
        if (reset) begin
            tx_cnt   <= cnt_w'(TX_CREDITS);
            tx_valid <= 1'b0;
        end else begin
            tx_valid <= tx_fire;
            case ({tx_fire, tx_credit})
                2'b10:   tx_cnt <= tx_cnt - 1'b1;
                2'b01:   tx_cnt <= tx_cnt + 1'b1;
                default: tx_cnt <= tx_cnt;   // Spend and refill cancel
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (tx_fire) tx_data <= wr_data;
    end

    // Receive side, sender only pushes while holding a credit
    assign data_in_avail = (rx_cnt != 2'd0);
    assign rx_push       = rx_valid && (rx_cnt != 2'd2);
    assign rx_pop        = rx_rd && data_in_avail;
    assign rx_byte       = rx_mem[rx_rd_ptr];    // FIFO head

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_wr_ptr <= 1'b0;
            rx_rd_ptr <= 1'b0;
            rx_cnt    <= 2'd0;
            rx_credit <= 1'b0;
        end else begin
            rx_credit <= rx_pop;           // Pulse the cycle after the pop
            if (rx_push) rx_wr_ptr <= ~rx_wr_ptr;
            if (rx_pop)  rx_rd_ptr <= ~rx_rd_ptr;
            case ({rx_push, rx_pop})
                2'b10:   rx_cnt <= rx_cnt + 2'd1;
                2'b01:   rx_cnt <= rx_cnt - 2'd1;
                default: rx_cnt <= rx_cnt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rx_push) rx_mem[rx_wr_ptr] <= rx_data;
    end

endmodule

`default_nettype wire

// File: rtl/cpu_core.sv
// CPU core top level forming the A and B buses, the write strobes and the flag register
`timescale 1ns/1ps
`default_nettype none

module cpu_core #(
    parameter int TX_CREDITS = 2,
    parameter int RAM_DEPTH  = 256
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [cpu_pkg::instr_w-1:0] instr,       // Same-cycle ROM data for pc
    input  logic                        tx_credit,
    input  logic                        rx_valid,
    input  logic [7:0]                  rx_data,
    output logic [15:0]                 pc,
    output logic                        tx_valid,
    output logic [7:0]                  tx_data,
    output logic                        rx_credit
);

    cpu_pkg::alu_op_e alu_op;
    cpu_pkg::adev_e   adev;
    cpu_pkg::bdev_e   bdev;
    cpu_pkg::tdev_e   tdev;
    cpu_pkg::cond_e   cond;
    logic             addr_direct;
    logic [7:0]       immed8;
    logic [7:0]       abus;
    logic [7:0]       bbus;
    logic [7:0]       result;       // ALU result bus, feeds every target
    logic [7:0]       alu_flags;
    logic [7:0]       flags;        // Flag register
    logic [7:0]       rf_a_data;
    logic [7:0]       rf_b_data;
    logic [7:0]       marlo;
    logic [7:0]       marhi;
    logic [7:0]       ram_rdata;
    logic [7:0]       rx_byte;
    logic             rf_wr_en;
    logic             pc_target;
    logic             data_in_avail;
    logic             data_out_ready;

    instr_decoder u_decoder (.instr, .alu_op, .adev, .bdev, .tdev, .cond, .addr_direct, .immed8);

    // A bus source mux
    always_comb begin
        case (adev)
            cpu_pkg::adev_marlo: abus = marlo;
            cpu_pkg::adev_marhi: abus = marhi;
            cpu_pkg::adev_uart:  abus = rx_byte;
            cpu_pkg::adev_zero:  abus = 8'd0;
            default:             abus = rf_a_data;   // Regs A..D
        endcase
    end

    // B bus source mux
    always_comb begin
        case (bdev)
            cpu_pkg::bdev_marlo: bbus = marlo;
            cpu_pkg::bdev_marhi: bbus = marhi;
            cpu_pkg::bdev_ram:   bbus = ram_rdata;
            cpu_pkg::bdev_immed: bbus = immed8;
            default:             bbus = rf_b_data;
        endcase
    end

    assign rf_wr_en  = tdev inside {[cpu_pkg::tdev_rega:cpu_pkg::tdev_regd]};
    assign pc_target = tdev inside {cpu_pkg::tdev_pclo, cpu_pkg::tdev_pchitmp, cpu_pkg::tdev_pc};

    register_file u_regs (
        .clk, .reset,
        .wr_en(rf_wr_en), .wr_addr(tdev[1:0]), .wr_data(result),
        .rd_a_addr(adev[1:0]), .rd_b_addr(bdev[1:0]),
        .rd_a_data(rf_a_data), .rd_b_data(rf_b_data)
    );

    alu u_alu (
        .a(abus), .b(bbus), .alu_op,
        .carry_in(flags[cpu_pkg::flag_c]),   // Carry chain through the flag register
        .result, .flags_out(alu_flags)
    );

    // Jumps keep the old flags so a compare can feed a two-step jump
    always_ff @(posedge clk) begin
        if (reset) flags <= '0;
        else if (!pc_target) flags <= alu_flags;
    end

    program_counter u_pc (
        .clk, .reset, .tdev, .cond, .flags,
        .data_in_avail, .data_out_ready, .result, .pc
    );

    data_memory #(.RAM_DEPTH(RAM_DEPTH)) u_mem (
        .clk, .reset, .tdev, .addr_direct,
        .direct_addr(immed8), .wr_data(result),
        .marlo, .marhi, .ram_rdata
    );

    uart_port #(.TX_CREDITS(TX_CREDITS)) u_uart (
        .clk, .reset,
        .tx_wr(tdev == cpu_pkg::tdev_uart), .wr_data(result),
        .rx_rd(adev == cpu_pkg::adev_uart),  // Reading the A bus pops the FIFO
        .tx_credit, .rx_valid, .rx_data,
        .tx_valid, .tx_data, .rx_credit, .rx_byte,
        .data_in_avail, .data_out_ready
    );

endmodule

`default_nettype wire

// File: verif/cpu_core_sva.sv
// Bound assertions on UART credit use and flag hold on jump cycles
`timescale 1ns/1ps
`default_nettype none

module cpu_core_sva (
    input logic           clk,
    input logic           reset,
    input cpu_pkg::adev_e adev,
    input cpu_pkg::tdev_e tdev,
    input logic           data_in_avail,
    input logic           data_out_ready,
    input logic           tx_valid,
    input logic           rx_credit,
    input logic [7:0]     flags
);

    int unsigned fail_count = 0;   // Read by the testbench for the closing report

    // Program must poll data-out before writing
    uart_write_has_credit: assert property (@(posedge clk) disable iff (reset)
        tdev == cpu_pkg::tdev_uart |-> data_out_ready)
        else begin
            fail_count++;
            $error("UART transmit written with no credit held");
        end

    // A beat only follows a write that held a credit
    tx_beat_needs_credit: assert property (@(posedge clk) disable iff (reset)
        tx_valid |-> $past(tdev == cpu_pkg::tdev_uart && data_out_ready))
        else begin
            fail_count++;
            $error("tx_valid raised without a credited write");
        end

    // Exactly one credit returned per popped byte, one cycle later
    rx_credit_per_pop: assert property (@(posedge clk) disable iff (reset)
        rx_credit == $past(adev == cpu_pkg::adev_uart && data_in_avail))
        else begin
            fail_count++;
            $error("rx_credit does not follow a receive pop");
        end

    // PC targets taken from the decoded target field
    jump_keeps_flags: assert property (@(posedge clk) disable iff (reset)
        tdev inside {cpu_pkg::tdev_pclo, cpu_pkg::tdev_pchitmp, cpu_pkg::tdev_pc}
            |=> $stable(flags))   // Two-step compare and jump relies on this
        else begin
            fail_count++;
            $error("Flags changed on a PC target cycle");
        end

endmodule

bind cpu_core cpu_core_sva u_sva (
    .clk, .reset, .adev, .tdev, .data_in_avail, .data_out_ready,
    .tx_valid, .rx_credit, .flags
);

`default_nettype wire

// File: verif/tb_cpu_core.sv
// Testbench for the CPU core with ROM model, UART partner, test programs and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_core;

    localparam int tx_credits      = 2;
    localparam int test_count      = 5;
    localparam int max_test_cycles = 800;   // Longest program with credit waits stays well below
    localparam int watchdog_cycles = test_count * max_test_cycles;

    logic        clk = 1'b0;
    logic        reset;
    logic [31:0] instr;
    logic        tx_credit;
    logic        rx_valid;
    logic [7:0]  rx_data;
    logic [15:0] pc;
    logic        tx_valid;
    logic [7:0]  tx_data;
    logic        rx_credit;

    logic [31:0] imem [512];     // Instruction ROM, pages 0 and 1
    logic [15:0] wp;             // Next word to write
    logic [15:0] halt_pc;
    logic [7:0]  exp_q [$];      // Bytes the program should send
    logic [7:0]  got_q [$];      // Bytes seen on tx
    logic [7:0]  rx_src [$];     // Bytes the partner still has to send
    int          credit_due [$]; // Cycle at which each tx credit goes back
    int          cycle;
    int          outstanding;
    int          rx_credits;
    int          rx_credit_total;
    int          rx_gap;
    int          errors = 0;
    int unsigned sva_fails;

    always #4 clk = ~clk;   // 8 ns period

    assign instr = imem[pc[8:0]];   // Same-cycle ROM read

    cpu_core #(.TX_CREDITS(tx_credits), .RAM_DEPTH(256)) dut (
        .clk, .reset, .instr, .tx_credit, .rx_valid, .rx_data,
        .pc, .tx_valid, .tx_data, .rx_credit
    );

    task automatic report_value(input string sig, input logic [15:0] got,
                                input logic [15:0] exp);
        errors++;
        $display("** Error %s: got 0x%h, expected 0x%h", sig, got, exp);
    endtask

    task automatic emit(input cpu_pkg::alu_op_e op, input cpu_pkg::tdev_e t,
                        input cpu_pkg::adev_e a, input cpu_pkg::bdev_e b,
                        input cpu_pkg::cond_e c, input logic direct, input logic [7:0] imm);
        imem[wp[8:0]] = {op, t, a, b, c, direct, 4'b0000, imm};
        wp++;
    endtask

    task automatic load_imm(input cpu_pkg::tdev_e t, input logic [7:0] v);
        emit(cpu_pkg::op_pass_b, t, cpu_pkg::adev_zero, cpu_pkg::bdev_immed,
             cpu_pkg::cond_always, 1'b0, v);
    endtask

    task automatic jump(input cpu_pkg::cond_e c, input logic [7:0] target);
        emit(cpu_pkg::op_pass_b, cpu_pkg::tdev_pc, cpu_pkg::adev_zero, cpu_pkg::bdev_immed,
             c, 1'b0, target);   // High byte from the temp register
    endtask

    task automatic local_jump(input logic [7:0] target);
        load_imm(cpu_pkg::tdev_pclo, target);
    endtask

    task automatic patch_target(input logic [15:0] idx);
        imem[idx[8:0]][7:0] = wp[7:0];   // Forward jump lands here
    endtask

    task automatic send(input cpu_pkg::alu_op_e op, input cpu_pkg::adev_e a,
                        input cpu_pkg::bdev_e b, input logic direct, input logic [7:0] imm);
        logic [15:0] start;
        start = wp;
        jump(cpu_pkg::cond_do, 8'(start + 16'd2));   // Credit held, go write
        local_jump(start[7:0]);                     // Spin until one comes back
        emit(op, cpu_pkg::tdev_uart, a, b, cpu_pkg::cond_always, direct, imm);
    endtask

    task automatic send_imm(input logic [7:0] v);
        send(cpu_pkg::op_pass_b, cpu_pkg::adev_zero, cpu_pkg::bdev_immed, 1'b0, v);
    endtask

    task automatic halt_here();
        halt_pc = wp;
        local_jump(wp[7:0]);
    endtask

    task automatic clear_program();
        // Unwritten words are nops, address sits in the spare and immediate bits
        for (int i = 0; i < 512; i++) begin
            imem[i] = 32'(i);
        end
        wp = '0;
        exp_q.delete();
    endtask

    // Add with carry jump, then subtract and xor
    task automatic arith_case(input logic [7:0] x, input logic [7:0] y);
        logic [8:0]  sum;
        logic [15:0] j;
        logic [15:0] k;
        load_imm(cpu_pkg::tdev_rega, x);
        load_imm(cpu_pkg::tdev_regb, y);
        emit(cpu_pkg::op_add, cpu_pkg::tdev_regc, cpu_pkg::adev_rega, cpu_pkg::bdev_regb,
             cpu_pkg::cond_always, 1'b0, 8'h00);
        j = wp;
        jump(cpu_pkg::cond_c, 8'h00);
        send_imm(8'h0C);              // No carry marker
        k = wp;
        jump(cpu_pkg::cond_always, 8'h00);
        patch_target(j);
        send_imm(8'hCC);              // Carry marker
        patch_target(k);
        send(cpu_pkg::op_pass_a, cpu_pkg::adev_regc, cpu_pkg::bdev_immed, 1'b0, 8'h00);
        emit(cpu_pkg::op_sub, cpu_pkg::tdev_regc, cpu_pkg::adev_rega, cpu_pkg::bdev_regb,
             cpu_pkg::cond_always, 1'b0, 8'h00);
        send(cpu_pkg::op_pass_a, cpu_pkg::adev_regc, cpu_pkg::bdev_immed, 1'b0, 8'h00);
        emit(cpu_pkg::op_xor, cpu_pkg::tdev_regc, cpu_pkg::adev_rega, cpu_pkg::bdev_regb,
             cpu_pkg::cond_always, 1'b0, 8'h00);
        send(cpu_pkg::op_pass_a, cpu_pkg::adev_regc, cpu_pkg::bdev_immed, 1'b0, 8'h00);
        sum = {1'b0, x} + {1'b0, y};
        exp_q.push_back(sum[8] ? 8'hCC : 8'h0C);
        exp_q.push_back(sum[7:0]);    // Wraps at 256
        exp_q.push_back(8'(x - y));
        exp_q.push_back(x ^ y);
    endtask

    // Direct write then MAR read, MAR write then direct read
    task automatic ram_case(input logic [7:0] addr, input logic [7:0] v1, input logic [7:0] v2);
        load_imm(cpu_pkg::tdev_rega, v1);
        emit(cpu_pkg::op_pass_a, cpu_pkg::tdev_ram, cpu_pkg::adev_rega, cpu_pkg::bdev_immed,
             cpu_pkg::cond_always, 1'b1, addr);
        load_imm(cpu_pkg::tdev_marlo, addr);
        send(cpu_pkg::op_pass_b, cpu_pkg::adev_zero, cpu_pkg::bdev_ram, 1'b0, 8'h00);
        load_imm(cpu_pkg::tdev_marlo, ~addr);
        load_imm(cpu_pkg::tdev_rega, v2);
        emit(cpu_pkg::op_pass_a, cpu_pkg::tdev_ram, cpu_pkg::adev_rega, cpu_pkg::bdev_regb,
             cpu_pkg::cond_always, 1'b0, 8'h00);
        send(cpu_pkg::op_pass_b, cpu_pkg::adev_zero, cpu_pkg::bdev_ram, 1'b1, ~addr);
        exp_q.push_back(v1);
        exp_q.push_back(v2);
    endtask

    // Poll data-in, pop and add one, send it back
    task automatic echo_incremented(input logic [7:0] b);
        logic [15:0] start;
        start = wp;
        jump(cpu_pkg::cond_di, 8'(start + 16'd2));
        local_jump(start[7:0]);
        emit(cpu_pkg::op_add, cpu_pkg::tdev_rega, cpu_pkg::adev_uart, cpu_pkg::bdev_immed,
             cpu_pkg::cond_always, 1'b0, 8'h01);
        send(cpu_pkg::op_pass_a, cpu_pkg::adev_rega, cpu_pkg::bdev_immed, 1'b0, 8'h00);
        rx_src.push_back(b);
        exp_q.push_back(8'(b + 8'd1));
    endtask

    task automatic jump_checks(input logic [7:0] v);
        logic [15:0] j;
        logic [15:0] k;
        load_imm(cpu_pkg::tdev_rega, v);
        load_imm(cpu_pkg::tdev_regb, v);
        emit(cpu_pkg::op_cmp, cpu_pkg::tdev_none, cpu_pkg::adev_rega, cpu_pkg::bdev_regb,
             cpu_pkg::cond_always, 1'b0, 8'h00);
        j = wp;
        jump(cpu_pkg::cond_eq, 8'h00);
        send_imm(8'hE0);
        k = wp;
        jump(cpu_pkg::cond_always, 8'h00);
        patch_target(j);
        send_imm(8'hE1);                                 // Equal path
        patch_target(k);
        send(cpu_pkg::op_pass_a, cpu_pkg::adev_rega, cpu_pkg::bdev_immed, 1'b0, 8'h00);
        send(cpu_pkg::op_pass_b, cpu_pkg::adev_zero, cpu_pkg::bdev_regb, 1'b0, 8'h00);
        emit(cpu_pkg::op_cmp, cpu_pkg::tdev_none, cpu_pkg::adev_rega, cpu_pkg::bdev_regb,
             cpu_pkg::cond_always, 1'b0, 8'h00);
        j = wp;
        jump(cpu_pkg::cond_ne, 8'h00);
        send_imm(8'h51);                                 // Not-equal not taken
        k = wp;
        jump(cpu_pkg::cond_always, 8'h00);
        patch_target(j);
        send_imm(8'h50);
        patch_target(k);
        load_imm(cpu_pkg::tdev_pchitmp, 8'h01);
        jump(cpu_pkg::cond_always, 8'h10);               // Over to 0x110
        wp = 16'h0110;
        local_jump(8'h20);                               // Must land at 0x120
        wp = 16'h0120;
        send_imm(8'h77);
        exp_q.push_back(8'hE1);
        exp_q.push_back(v);
        exp_q.push_back(v);
        exp_q.push_back(8'h51);
        exp_q.push_back(8'h77);
    endtask

    task automatic check_stream(input string name);
        assert (got_q.size() == exp_q.size()) else begin
            errors++;
            $display("%s program sent %0d bytes where %0d were expected",
                     name, got_q.size(), exp_q.size());
        end
        for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
            assert (got_q[i] == exp_q[i])
                else report_value($sformatf("%s tx_data[%0d]", name, i), got_q[i], exp_q[i]);
        end
    endtask

    task automatic run_program(input string name);
        reset = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        assert (pc == 16'h0000) else report_value("pc", pc, 16'h0000);
        assert (!tx_valid) else report_value("tx_valid", 16'(tx_valid), 16'h0000);
        assert (!rx_credit) else report_value("rx_credit", 16'(rx_credit), 16'h0000);
        reset = 1'b0;
        while (pc != halt_pc) begin
            @(posedge clk);
            #1;
        end
        repeat (4) @(posedge clk);   // Let the last beat reach the partner
        #1;
        check_stream(name);
    endtask

    // UART partner, samples and drives 1 ns after the edge
    always @(posedge clk) begin
        #1;
        cycle++;
        tx_credit = 1'b0;
        rx_valid  = 1'b0;
        if (reset) begin
            got_q.delete();
            credit_due.delete();
            outstanding     = 0;
            rx_credits      = 2;   // Receive FIFO depth
            rx_credit_total = 0;
            rx_gap          = 0;
        end else begin
            if (tx_valid) begin
                got_q.push_back(tx_data);
                outstanding++;
                credit_due.push_back(cycle + int'($urandom_range(6, 1)));
            end
            assert (outstanding <= tx_credits)
                else report_value("outstanding", 16'(outstanding), 16'(tx_credits));
            if (credit_due.size() != 0 && cycle >= credit_due[0]) begin
                void'(credit_due.pop_front());
                tx_credit = 1'b1;
                outstanding--;
            end
            if (rx_credit) begin
                rx_credits++;
                rx_credit_total++;
            end
            assert (rx_credits <= 2) else report_value("rx credits", 16'(rx_credits), 16'h0002);
            if (rx_gap != 0) begin
                rx_gap--;
            end else if (rx_src.size() != 0 && rx_credits != 0) begin
                rx_data  = rx_src.pop_front();
                rx_valid = 1'b1;                          // Spends one credit
                rx_credits--;
                rx_gap   = int'($urandom_range(3, 0));
            end
        end
    end

    initial begin
        #(watchdog_cycles * 8);
        $display("Watchdog expired after %0d cycles, a program never reached its halt loop",
                 watchdog_cycles);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        void'($urandom(86));
        reset     = 1'b1;
        tx_credit = 1'b0;
        rx_valid  = 1'b0;
        rx_data   = 8'h00;
        cycle     = 0;

        clear_program();
        arith_case(8'h37, 8'h25);
        arith_case(8'hC8, 8'h64);                   // Sum over 255
        arith_case(8'($urandom), 8'($urandom));
        halt_here();
        run_program("arithmetic");

        clear_program();
        for (int i = 0; i < 3; i++) begin
            ram_case(8'($urandom), 8'($urandom), 8'($urandom));
        end
        halt_here();
        run_program("ram");

        clear_program();
        for (int i = 0; i < 10; i++) begin
            exp_q.push_back(8'($urandom));
            send_imm(exp_q[i]);
        end
        halt_here();
        run_program("tx credits");

        clear_program();
        for (int i = 0; i < 8; i++) begin
            echo_incremented(8'($urandom));
        end
        halt_here();
        run_program("rx credits");
        assert (rx_credit_total == 8) else report_value("rx_credit pulses", 16'(rx_credit_total), 16'd8);

        clear_program();
        jump_checks(8'($urandom));
        halt_here();                                 // In page 1
        run_program("jumps");

        sva_fails = dut.u_sva.fail_count;
        $display("Closing report: %0d testbench errors, %0d assertion failures",
                 errors, sva_fails);
        if (errors == 0 && sva_fails == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
rtl/cpu_pkg.sv
rtl/instr_decoder.sv
rtl/program_counter.sv
rtl/register_file.sv
rtl/alu.sv
rtl/data_memory.sv
rtl/uart_port.sv
rtl/cpu_core.sv
verif/cpu_core_sva.sv
verif/tb_cpu_core.sv

// File: run.sh
#!/bin/sh
# Build and run the CPU core testbench with Verilator, pass is decided from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/1ps \
    --top-module tb_cpu_core \
    -f src.f \
    -o sim_cpu_core

# Keep running past assertion errors so the testbench prints its own verdict
./obj_dir/sim_cpu_core +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation passed$" sim.log; then
    exit 0
fi
exit 1
